// ==== build.f ====
source/irq_ctrl_pkg.sv
source/irq_csr_if.sv
source/irq_input_sync.sv
source/irq_line_slice.sv
source/irq_priority_select.sv
source/irq_context_csr.sv
source/irq_ctrl_top.sv
testbench/tb_irq_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the interrupt controller regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_irq_ctrl -Mdir obj_dir -o sim_irq_ctrl
./obj_dir/sim_irq_ctrl > sim.log 2>&1
cat sim.log

if grep -q "Regression passed" sim.log; then
	exit 0
fi
exit 1

// ==== testbench/tb_irq_ctrl.sv ====
`timescale 1ns/1ns

module tb_irq_ctrl;
	import irq_ctrl_pkg::*;

	logic                clk;
	logic                rst_n;
	logic [num_irqs-1:0] irq;
	logic [11:0]         csr_addr;
	logic                csr_wen;
	logic                csr_ren;
	logic [data_w-1:0]   csr_wdata;
	logic [data_w-1:0]   csr_rdata;
	logic                trap_enter;
	logic                trap_enter_is_eirq;
	logic                trap_exit;
	logic                irq_pending;

	// Reference model of the line state and the context register
	logic [num_irqs-1:0] en_m;
	logic [num_irqs-1:0] force_m;
	logic [num_irqs-1:0] lvl_m;
	prio_t               prio_m [num_irqs];
	irq_context_t        ctx_m;
	logic [31:0]         lfsr;
	int                  errors;
	int                  tests;

	irq_ctrl_top dut_i (
		.clk                (clk),
		.rst_n              (rst_n),
		.irq                (irq),
		.csr_addr           (csr_addr),
		.csr_wen            (csr_wen),
		.csr_ren            (csr_ren),
		.csr_wdata          (csr_wdata),
		.csr_rdata          (csr_rdata),
		.trap_enter         (trap_enter),
		.trap_enter_is_eirq (trap_enter_is_eirq),
		.trap_exit          (trap_exit),
		.irq_pending        (irq_pending)
	);

	always #50 clk = ~clk;

	// --------------------
	// Random source

	// Galois LFSR, one step per bit handed out
	function automatic logic lfsr_next();
		logic out;
		out = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_next()};
		end
		return v;
	endfunction

	// --------------------
	// Compare tasks

	task automatic check_data(input string name, input logic [data_w-1:0] got,
			input logic [data_w-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic compare_field(input string name, input string field, input logic [7:0] got,
			input logic [7:0] exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s.%s got %0d expected %0d", $time, name, field,
				got, exp);
		end
	endtask

	// Unpacks a context read into the struct, bit 1 is the live request and is skipped
	task automatic check_context(input string name, input logic [data_w-1:0] raw,
			input irq_context_t exp);
		irq_context_t got;
		got.pppreempt = raw[31:28];
		got.ppreempt  = raw[27:24];
		got.preempt   = raw[20:16];
		got.noirq     = raw[15];
		got.irq       = raw[8:4];
		got.mreteirq  = raw[0];
		compare_field(name, "pppreempt", 8'(got.pppreempt), 8'(exp.pppreempt));
		compare_field(name, "ppreempt", 8'(got.ppreempt), 8'(exp.ppreempt));
		compare_field(name, "preempt", 8'(got.preempt), 8'(exp.preempt));
		compare_field(name, "noirq", 8'(got.noirq), 8'(exp.noirq));
		compare_field(name, "irq", 8'(got.irq), 8'(exp.irq));
		compare_field(name, "mreteirq", 8'(got.mreteirq), 8'(exp.mreteirq));
	endtask

	// --------------------
	// Drive tasks

	// Every drive task starts and ends 5 ns after a rising edge
	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic csr_write(input csr_addr_e addr, input logic [data_w-1:0] data);
		csr_addr  = addr;
		csr_wdata = data;
		csr_wen   = 1'b1;
		next_cycle();
		csr_wen = 1'b0;
	endtask

	// Read data settles well before the falling edge, ren only matters for the claim
	task automatic csr_read(input csr_addr_e addr, input logic [data_w-1:0] window,
			output logic [data_w-1:0] data);
		csr_addr  = addr;
		csr_wdata = window;
		csr_ren   = 1'b1;
		@(negedge clk);
		data = csr_rdata;
		next_cycle();
		csr_ren = 1'b0;
	endtask

	task automatic wait_pending(input logic exp);
		int n;
		n = 0;
		while (irq_pending !== exp && n < 20) begin
			next_cycle();
			n++;
		end
		if (irq_pending !== exp) begin
			errors++;
			$display("Timeout at %0t: irq_pending did not become %b in 20 cycles", $time, exp);
		end
	endtask

	task automatic write_context(input irq_context_t c);
		csr_write(addr_context, {c.pppreempt, c.ppreempt, 3'b0, c.preempt, c.noirq, 6'b0,
			c.irq, 3'b0, c.mreteirq});
		ctx_m = c;
	endtask

	// --------------------
	// Reference model

	function automatic logic model_pending(input preempt_t p);
		logic r;
		r = 1'b0;
		for (int i = 0; i < num_irqs; i++) begin
			if ((lvl_m[i] | force_m[i]) && en_m[i] && {1'b0, prio_m[i]} >= p) r = 1'b1;
		end
		return r;
	endfunction

	// First the top priority among claimable lines, then the lowest line holding it
	task automatic model_next(output logic noirq, output irq_idx_t idx, output prio_t pr);
		logic [num_irqs-1:0] ok;
		noirq = 1'b1;
		idx   = '0;
		pr    = '0;
		for (int i = 0; i < num_irqs; i++) begin
			ok[i] = (lvl_m[i] | force_m[i]) && en_m[i] && prio_m[i] >= ctx_m.ppreempt;
			if (ok[i]) begin
				noirq = 1'b0;
				if (prio_m[i] > pr) pr = prio_m[i];
			end
		end
		for (int i = num_irqs - 1; i >= 0; i--) begin
			if (ok[i] && prio_m[i] == pr) idx = irq_idx_t'(i);
		end
	endtask

	function automatic preempt_t level_of(input logic noirq, input prio_t pr);
		return noirq ? 5'd16 : 5'({1'b0, pr} + 5'd1);
	endfunction

	function automatic logic [data_w-1:0] next_value(input logic noirq, input irq_idx_t idx);
		return (32'(noirq) << 31) | (32'(idx) << 4);
	endfunction

	// Pulses the trap inputs for one edge, then reads the context back
	task automatic trap_and_check(input logic enter, input logic eirq, input logic exit_t);
		logic        nq;
		irq_idx_t    idx;
		prio_t       pr;
		logic [31:0] rd;
		model_next(nq, idx, pr);
		if (enter && eirq) begin
			ctx_m.pppreempt = ctx_m.ppreempt;
			ctx_m.ppreempt  = ctx_m.preempt[3:0];
			ctx_m.preempt   = level_of(nq, pr);
			ctx_m.mreteirq  = 1'b1;
		end else if (enter) begin
			ctx_m.mreteirq = 1'b0;
		end else if (exit_t && ctx_m.mreteirq) begin
			ctx_m.preempt   = {1'b0, ctx_m.ppreempt};
			ctx_m.ppreempt  = ctx_m.pppreempt;
			ctx_m.pppreempt = '0;
			ctx_m.mreteirq  = 1'b0;
		end
		trap_enter         = enter;
		trap_enter_is_eirq = eirq;
		trap_exit          = exit_t;
		next_cycle();
		trap_enter         = 1'b0;
		trap_enter_is_eirq = 1'b0;
		trap_exit          = 1'b0;
		csr_read(addr_context, 0, rd);
		check_context("context after trap", rd, ctx_m);
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests++;
		$display("%s: %s", name, (errors == errors_before) ? "ok" : "mismatches");
	endtask

	// --------------------
	// Directed tests

	task automatic reset_values();
		logic [31:0] rd;
		int          e0;
		e0 = errors;
		csr_read(addr_context, 0, rd);
		check_context("context", rd, ctx_m);
		check_bit("irq_pending", irq_pending, 1'b0);
		csr_read(addr_next, 0, rd);
		check_data("next", rd, 32'h8000_0000);
		end_test("reset values", e0);
	endtask

	task automatic array_access();
		logic [15:0] v;
		logic [31:0] rd;
		logic [31:0] exp;
		int          e0;
		e0 = errors;
		for (int w = 0; w < 2; w++) begin
			v = 16'(rand_bits(16));
			csr_write(addr_en_array, {v, 11'b0, 5'(w)});
			en_m[w*16 +: 16] = v;
		end
		// A write past line 31 must not land in any real window
		csr_write(addr_en_array, {16'hffff, 11'b0, 5'd2});
		for (int w = 0; w < 8; w++) begin
			v = 16'(rand_bits(16));
			csr_write(addr_prio_array, {v, 9'b0, 7'(w)});
			for (int k = 0; k < 4; k++) prio_m[w*4 + k] = v[4*k +: 4];
		end
		for (int w = 0; w < 2; w++) begin
			csr_read(addr_en_array, 32'(w), rd);
			check_data("enable window", rd, {en_m[w*16 +: 16], 16'h0});
		end
		for (int w = 0; w < 8; w++) begin
			exp = '0;
			for (int k = 0; k < 4; k++) exp[16 + 4*k +: 4] = prio_m[w*4 + k];
			csr_read(addr_prio_array, 32'(w), rd);
			check_data("priority window", rd, exp);
		end
		// Windows past line 31 are empty
		csr_read(addr_en_array, 32'd2, rd);
		check_data("enable window 2", rd, 32'h0);
		csr_read(addr_en_array, 32'd31, rd);
		check_data("enable window 31", rd, 32'h0);
		csr_read(addr_prio_array, 32'd8, rd);
		check_data("priority window 8", rd, 32'h0);
		csr_read(addr_prio_array, 32'd127, rd);
		check_data("priority window 127", rd, 32'h0);
		irq   = rand_bits(32);
		lvl_m = irq;
		next_cycle();
		for (int w = 0; w < 2; w++) begin
			csr_read(addr_pend_array, 32'(w), rd);
			check_data("pending window", rd, {lvl_m[w*16 +: 16], 16'h0});
		end
		end_test("array access", e0);
	endtask

	task automatic pending_rule();
		irq_context_t c;
		logic [31:0]  rd;
		int           e0;
		e0 = errors;
		for (int n = 0; n < 8; n++) begin
			irq   = rand_bits(32);
			lvl_m = irq;
			next_cycle();
			c         = '0;
			c.noirq   = 1'b1;
			c.preempt = (n == 0) ? 5'd0 : (n == 7) ? 5'd16 : 5'(rand_bits(5));
			write_context(c);
			check_bit("irq_pending", irq_pending, model_pending(c.preempt));
			// The context readback carries the same request in bit 1
			csr_read(addr_context, 0, rd);
			check_bit("context pending bit", rd[1], model_pending(c.preempt));
		end
		end_test("pending rule", e0);
	endtask

	task automatic next_selection();
		irq_context_t c;
		logic         nq;
		irq_idx_t     idx;
		prio_t        pr;
		logic [31:0]  rd;
		int           e0;
		e0 = errors;
		for (int n = 0; n < 6; n++) begin
			c          = '0;
			c.noirq    = 1'b1;
			c.ppreempt = (n == 5) ? 4'd15 : 4'(rand_bits(4));
			write_context(c);
			model_next(nq, idx, pr);
			csr_read(addr_next, 0, rd);
			check_data("next", rd, next_value(nq, idx));
			// Taking the next line raises the live level above it
			csr_write(addr_next, 32'h1);
			ctx_m.preempt = level_of(nq, pr);
			ctx_m.noirq   = nq;
			ctx_m.irq     = idx;
			csr_read(addr_context, 0, rd);
			check_context("context after next write", rd, ctx_m);
		end
		end_test("next selection", e0);
	endtask

	task automatic force_and_claim();
		logic         nq;
		irq_idx_t     idx;
		prio_t        pr;
		logic [31:0]  rd;
		int           e0;
		e0    = errors;
		irq   = '0;
		lvl_m = '0;
		next_cycle();
		// Only line 13 stays enabled, at priority 9
		csr_write(addr_en_array, {16'h2000, 16'd0});
		csr_write(addr_en_array, {16'h0000, 16'd1});
		en_m = 32'h0000_2000;
		csr_write(addr_prio_array, {16'h0090, 16'd3});
		prio_m[12] = 4'd0;
		prio_m[13] = 4'd9;
		prio_m[14] = 4'd0;
		prio_m[15] = 4'd0;
		write_context('0);
		check_bit("irq_pending", irq_pending, 1'b0);
		csr_write(addr_force_array, {16'h2000, 16'd0});
		force_m[13] = 1'b1;
		wait_pending(1'b1);
		csr_read(addr_force_array, 0, rd);
		check_data("force window", rd, 32'h2000_0000);
		model_next(nq, idx, pr);
		csr_read(addr_next, 0, rd);
		check_data("next", rd, next_value(nq, idx));
		force_m[13] = 1'b0;
		csr_read(addr_force_array, 0, rd);
		check_data("force window after claim", rd, 32'h0);
		wait_pending(1'b0);
		end_test("force and claim", e0);
	endtask

	task automatic preemption_stack();
		irq_context_t c;
		int           e0;
		e0        = errors;
		irq[13]   = 1'b1;
		lvl_m[13] = 1'b1;
		next_cycle();
		c          = '0;
		c.preempt  = 5'd3;
		c.ppreempt = 4'd2;
		write_context(c);
		trap_and_check(1'b1, 1'b1, 1'b0);
		trap_and_check(1'b1, 1'b1, 1'b0);
		trap_and_check(1'b0, 1'b0, 1'b1);
		trap_and_check(1'b0, 1'b0, 1'b1);
		// A synchronous trap in between means the exit restores nothing
		trap_and_check(1'b1, 1'b1, 1'b0);
		trap_and_check(1'b1, 1'b0, 1'b0);
		trap_and_check(1'b0, 1'b0, 1'b1);
		end_test("preemption stack", e0);
	endtask

	// --------------------
	// Sequence

	initial begin
		clk                = 1'b0;
		rst_n              = 1'b0;
		irq                = '0;
		csr_addr           = '0;
		csr_wen            = 1'b0;
		csr_ren            = 1'b0;
		csr_wdata          = '0;
		trap_enter         = 1'b0;
		trap_enter_is_eirq = 1'b0;
		trap_exit          = 1'b0;
		en_m               = '0;
		force_m            = '0;
		lvl_m              = '0;
		for (int i = 0; i < num_irqs; i++) prio_m[i] = '0;
		ctx_m       = '0;
		ctx_m.noirq = 1'b1;
		lfsr        = 32'd84826;
		errors      = 0;
		tests       = 0;
		repeat (16) @(posedge clk);
		#5;
		rst_n = 1'b1;
		next_cycle();
		reset_values();
		array_access();
		pending_rule();
		next_selection();
		force_and_claim();
		preemption_stack();
		$display("Tests run %0d, failed checks %0d", tests, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== source/irq_ctrl_top.sv ====
`timescale 1ns/1ns

module irq_ctrl_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [irq_ctrl_pkg::num_irqs-1:0] irq,
	input  logic [11:0]                       csr_addr,
	input  logic                              csr_wen,
	input  logic                              csr_ren,
	input  logic [irq_ctrl_pkg::data_w-1:0]   csr_wdata,
	output logic [irq_ctrl_pkg::data_w-1:0]   csr_rdata,
	input  logic                              trap_enter,
	input  logic                              trap_enter_is_eirq,
	input  logic                              trap_exit,
	output logic                              irq_pending
);
	import irq_ctrl_pkg::*;

	logic [num_irqs-1:0]  irq_sync;
	logic [num_irqs-1:0]  enable_bits;
	logic [num_irqs-1:0]  force_bits;
	logic [num_irqs-1:0]  pend_bits;
	logic [num_irqs-1:0]  req_preempt;
	logic [num_irqs-1:0]  req_ppreempt;
	prio_t [num_irqs-1:0] prio_array;
	preempt_t             preempt;
	prio_t                ppreempt;
	logic                 claim;
	irq_idx_t             claim_idx;
	logic                 next_noirq;
	irq_idx_t             next_irq;
	prio_t                next_prio;

	// --------------------
	// CSR bundle

	irq_csr_if csr_bus ();

	// Unknown addresses keep their value and simply miss every decoder
	assign csr_bus.addr  = csr_addr_e'(csr_addr);
	assign csr_bus.wen   = csr_wen;
	assign csr_bus.ren   = csr_ren;
	assign csr_bus.wdata = csr_wdata;

	// --------------------
	// Blocks

	irq_input_sync u_input_sync (
		.clk      (clk),
		.rst_n    (rst_n),
		.irq      (irq),
		.irq_sync (irq_sync)
	);

	for (genvar g = 0; g < num_irqs; g++) begin : g_line
		irq_line_slice u_slice (
			.clk          (clk),
			.rst_n        (rst_n),
			.line_index   (irq_idx_t'(g)),
			.csr          (csr_bus.line),
			.irq_sync     (irq_sync[g]),
			.preempt      (preempt),
			.ppreempt     (ppreempt),
			.claim        (claim),
			.claim_idx    (claim_idx),
			.enable       (enable_bits[g]),
			.force_bit    (force_bits[g]),
			.pend         (pend_bits[g]),
			.prio         (prio_array[g]),
			.req_preempt  (req_preempt[g]),
			.req_ppreempt (req_ppreempt[g])
		);
	end

	irq_priority_select u_priority_select (
		.req_preempt  (req_preempt),
		.req_ppreempt (req_ppreempt),
		.prio_array   (prio_array),
		.irq_pending  (irq_pending),
		.next_noirq   (next_noirq),
		.next_irq     (next_irq),
		.next_prio    (next_prio)
	);

	irq_context_csr u_context_csr (
		.clk                (clk),
		.rst_n              (rst_n),
		.csr                (csr_bus.regs),
		.trap_enter         (trap_enter),
		.trap_enter_is_eirq (trap_enter_is_eirq),
		.trap_exit          (trap_exit),
		.next_noirq         (next_noirq),
		.next_irq           (next_irq),
		.next_prio          (next_prio),
		.irq_pending        (irq_pending),
		.enable_bits        (enable_bits),
		.force_bits         (force_bits),
		.pend_bits          (pend_bits),
		.prio_array         (prio_array),
		.preempt            (preempt),
		.ppreempt           (ppreempt),
		.claim              (claim),
		.claim_idx          (claim_idx),
		.rdata              (csr_rdata)
	);

endmodule

// ==== source/irq_context_csr.sv ====
`timescale 1ns/1ns

module irq_context_csr (
	input  logic                                             clk,
	input  logic                                             rst_n,
	irq_csr_if.regs                                          csr,
	input  logic                                             trap_enter,
	input  logic                                             trap_enter_is_eirq,
	input  logic                                             trap_exit,
	input  logic                                             next_noirq,
	input  irq_ctrl_pkg::irq_idx_t                           next_irq,
	input  irq_ctrl_pkg::prio_t                              next_prio,
	input  logic                                             irq_pending,
	input  logic [irq_ctrl_pkg::num_irqs-1:0]                enable_bits,
	input  logic [irq_ctrl_pkg::num_irqs-1:0]                force_bits,
	input  logic [irq_ctrl_pkg::num_irqs-1:0]                pend_bits,
	input  irq_ctrl_pkg::prio_t [irq_ctrl_pkg::num_irqs-1:0] prio_array,
	output irq_ctrl_pkg::preempt_t                           preempt,
	output irq_ctrl_pkg::prio_t                              ppreempt,
	output logic                                             claim,
	output irq_ctrl_pkg::irq_idx_t                           claim_idx,
	output logic [irq_ctrl_pkg::data_w-1:0]                  rdata
);
	import irq_ctrl_pkg::*;

	irq_context_t ctx;
	preempt_t     level_next;
	logic [4:0]   bit_win;
	logic [6:0]   prio_win;
	logic         bit_win_ok;
	logic         prio_win_ok;

	// --------------------
	// Context register

	// Level that masks everything up to and including the next interrupt
	assign level_next = next_noirq ? 5'd16 : ({1'b0, next_prio} + 5'd1);

	// Trap events outrank software writes, a trap entry outranks an exit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctx       <= '0;
			ctx.noirq <= 1'b1;
		end else if (trap_enter) begin
			if (trap_enter_is_eirq) begin
				// Push the stack, the top bit of preempt is never saved since a
				// level of 16 cannot have been preempted
				ctx.pppreempt <= ctx.ppreempt;
				ctx.ppreempt  <= ctx.preempt[3:0];
				ctx.preempt   <= level_next;
				ctx.mreteirq  <= 1'b1;
			end else begin
				ctx.mreteirq <= 1'b0;
			end
		end else if (trap_exit) begin
			ctx.mreteirq <= 1'b0;
			if (ctx.mreteirq) begin
				// Pop the stack, only after an external interrupt trap
				ctx.preempt   <= {1'b0, ctx.ppreempt};
				ctx.ppreempt  <= ctx.pppreempt;
				ctx.pppreempt <= '0;
			end
		end else if (csr.wen && csr.addr == addr_context) begin
			ctx.pppreempt <= csr.wdata[31:28];
			ctx.ppreempt  <= csr.wdata[27:24];
			ctx.preempt   <= csr.wdata[20:16];
			ctx.noirq     <= csr.wdata[15];
			ctx.irq       <= csr.wdata[8:4];
			ctx.mreteirq  <= csr.wdata[0];
		end else if (csr.wen && csr.addr == addr_next && csr.wdata[0]) begin
			// Software took the next interrupt and asks for the context update
			ctx.preempt <= level_next;
			ctx.noirq   <= next_noirq;
			ctx.irq     <= next_irq;
		end
	end

	assign preempt  = ctx.preempt;
	assign ppreempt = ctx.ppreempt;

	// Reading the next register claims the line it shows
	assign claim     = csr.ren && (csr.addr == addr_next) && !next_noirq;
	assign claim_idx = next_irq;

	// --------------------
	// Readback

	assign bit_win     = csr.wdata[4:0];
	assign prio_win    = csr.wdata[6:0];
	assign bit_win_ok  = bit_win < 5'(num_irqs / lines_per_bit_window);
	assign prio_win_ok = prio_win < 7'(num_irqs / lines_per_prio_window);

	always_comb begin
		rdata = '0;
		case (csr.addr)
			addr_en_array: if (bit_win_ok) begin
				rdata[31:16] = enable_bits[bit_win * lines_per_bit_window +: lines_per_bit_window];
			end
			addr_pend_array: if (bit_win_ok) begin
				rdata[31:16] = pend_bits[bit_win * lines_per_bit_window +: lines_per_bit_window];
			end
			addr_force_array: if (bit_win_ok) begin
				rdata[31:16] = force_bits[bit_win * lines_per_bit_window +: lines_per_bit_window];
			end
			addr_prio_array: if (prio_win_ok) begin
				rdata[31:16] = prio_array[prio_win * lines_per_prio_window +: lines_per_prio_window];
			end
			addr_next: begin
				rdata[31]  = next_noirq;
				rdata[8:4] = next_irq;
			end
			addr_context: begin
				rdata[31:28] = ctx.pppreempt;
				rdata[27:24] = ctx.ppreempt;
				rdata[20:16] = ctx.preempt;
				rdata[15]    = ctx.noirq;
				rdata[8:4]   = ctx.irq;
				// Read-only view of the request to the core, writes ignore it
				rdata[1]     = irq_pending;
				rdata[0]     = ctx.mreteirq;
			end
			default: rdata = '0;
		endcase
	end

endmodule

// ==== source/irq_priority_select.sv ====
`timescale 1ns/1ns

module irq_priority_select (
	input  logic [irq_ctrl_pkg::num_irqs-1:0]                      req_preempt,
	input  logic [irq_ctrl_pkg::num_irqs-1:0]                      req_ppreempt,
	input  irq_ctrl_pkg::prio_t [irq_ctrl_pkg::num_irqs-1:0]       prio_array,
	output logic                                                   irq_pending,
	output logic                                                   next_noirq,
	output irq_ctrl_pkg::irq_idx_t                                 next_irq,
	output irq_ctrl_pkg::prio_t                                    next_prio
);
	import irq_ctrl_pkg::*;

	// --------------------
	// Summary flags

	// Any enabled pending line at or above the live level interrupts the core
	assign irq_pending = |req_preempt;

	// Nothing claimable when no line clears the saved level
	assign next_noirq = ~|req_ppreempt;

	// --------------------
	// Highest priority scan

	// Walk up from line 0 and only replace the winner on a strictly higher
	// priority, which leaves ties with the lowest index.
	// With no claimable line both outputs stay at zero
	always_comb begin
		logic found;
		found     = 1'b0;
		next_irq  = '0;
		next_prio = '0;
		for (int i = 0; i < num_irqs; i++) begin
			if (req_ppreempt[i] && (!found || prio_array[i] > next_prio)) begin
				found     = 1'b1;
				next_irq  = irq_idx_t'(i);
				next_prio = prio_array[i];
			end
		end
	end

	// The priority of the winner feeds the next preemption level, so it is
	// taken from the same scan rather than from a second selector

endmodule

// ==== source/irq_line_slice.sv ====
`timescale 1ns/1ns

module irq_line_slice (
	input  logic                   clk,
	input  logic                   rst_n,
	input  irq_ctrl_pkg::irq_idx_t line_index,
	irq_csr_if.line                csr,
	input  logic                   irq_sync,
	input  irq_ctrl_pkg::preempt_t preempt,
	input  irq_ctrl_pkg::prio_t    ppreempt,
	input  logic                   claim,
	input  irq_ctrl_pkg::irq_idx_t claim_idx,
	output logic                   enable,
	output logic                   force_bit,
	output logic                   pend,
	output irq_ctrl_pkg::prio_t    prio,
	output logic                   req_preempt,
	output logic                   req_ppreempt
);
	import irq_ctrl_pkg::*;

	logic [4:0] bit_window;
	logic [6:0] prio_window;
	logic [3:0] bit_pos;
	logic [1:0] nib_pos;
	logic       bit_window_hit;
	logic       wbit;
	prio_t      wnib;
	logic       claim_hit;

	// --------------------
	// Window decode

	// Which window of each array holds this line, and where inside it
	assign bit_window  = 5'(line_index / lines_per_bit_window);
	assign prio_window = 7'(line_index / lines_per_prio_window);
	assign bit_pos     = 4'(line_index % lines_per_bit_window);
	assign nib_pos     = 2'(line_index % lines_per_prio_window);

	// The window number rides in the low data bits, the payload in the top half
	assign bit_window_hit = csr.wen && (csr.wdata[4:0] == bit_window);
	assign wbit           = csr.wdata[16 + bit_pos];
	assign wnib           = csr.wdata[16 + 4 * nib_pos +: 4];

	// The core has just read this line out of the next register
	assign claim_hit = claim && (claim_idx == line_index);

	// --------------------
	// Line state

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable    <= 1'b0;
			force_bit <= 1'b0;
			prio      <= '0;
		end else begin
			if (bit_window_hit && csr.addr == addr_en_array) begin
				enable <= wbit;
			end
			// A claim wins over a force write on the same edge, so a forced
			// interrupt is posted exactly once
			if (claim_hit) begin
				force_bit <= 1'b0;
			end else if (bit_window_hit && csr.addr == addr_force_array) begin
				force_bit <= wbit;
			end
			if (csr.wen && csr.addr == addr_prio_array && csr.wdata[6:0] == prio_window) begin
				prio <= wnib;
			end
		end
	end

	// --------------------
	// Request comparisons

	assign pend = irq_sync | force_bit;

	// Against the live level, this drives the pending signal to the core
	assign req_preempt  = pend && enable && ({1'b0, prio} >= preempt);
	// Against the saved level, this decides what the next register offers
	assign req_ppreempt = pend && enable && (prio >= ppreempt);

endmodule

// ==== source/irq_input_sync.sv ====
`timescale 1ns/1ns

module irq_input_sync (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [irq_ctrl_pkg::num_irqs-1:0] irq,
	output logic [irq_ctrl_pkg::num_irqs-1:0] irq_sync
);
	import irq_ctrl_pkg::*;

	// --------------------
	// Input flops

	// One flop per line so the request logic never sees the pins directly.
	// The lines are level sensitive, so a single register stage is enough
	// and the added latency is exactly one edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// Lines read as inactive until the first edge after reset
			irq_sync <= '0;
		end else begin
			irq_sync <= irq;
		end
	end

	// Nothing else lives here, the slices pick up their own bit

endmodule

// ==== source/irq_csr_if.sv ====
`timescale 1ns/1ns

// CSR access bundle shared by the line slices and the context block
interface irq_csr_if;
	import irq_ctrl_pkg::*;

	// Address of the access, already cast to the known CSR set
	csr_addr_e         addr;
	logic              wen;
	logic              ren;
	// Write data, which also carries the window number on array reads
	logic [data_w-1:0] wdata;

	// Slices only look at writes, and at the address for window decoding
	modport line (
		input addr, wen, ren, wdata
	);

	// Context block decodes every access for its registers and readback
	modport regs (
		input addr, wen, ren, wdata
	);

endinterface

// ==== source/irq_ctrl_pkg.sv ====
package irq_ctrl_pkg;

	// --------------------
	// Sizes

	// Number of external interrupt lines handled by the controller
	localparam int num_irqs = 32;

	// Width of a line index, enough to name every line
	localparam int irq_idx_w = 5;

	// Width of the CSR data path
	localparam int data_w = 32;

	// One window of the enable, force and pending arrays covers 16 lines
	localparam int lines_per_bit_window = 16;

	// One window of the priority array covers four 4-bit priorities
	localparam int lines_per_prio_window = 4;

	// --------------------
	// Types

	// Interrupt priority, a higher value wins
	typedef logic [3:0] prio_t;

	// Preemption level, one bit wider than a priority so that 16 blocks everything
	typedef logic [4:0] preempt_t;

	typedef logic [irq_idx_w-1:0] irq_idx_t;

	// CSR addresses decoded by the controller
	typedef enum logic [11:0] {
		addr_en_array    = 12'hbe0,
		addr_pend_array  = 12'hbe1,
		addr_force_array = 12'hbe2,
		addr_prio_array  = 12'hbe3,
		addr_next        = 12'hbe4,
		addr_context     = 12'hbe5
	} csr_addr_e;

	// Preemption context, the two saved levels sit above the live one
	typedef struct packed {
		prio_t    pppreempt;
		prio_t    ppreempt;
		preempt_t preempt;
		logic     noirq;
		irq_idx_t irq;
		logic     mreteirq;
	} irq_context_t;

endpackage
